// ==== Bender.yml ====
package:
  name: ysyx_23060208_exec

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/ysyx_23060208_pkg.sv
      - verilog/ysyx_23060208_idu.sv
      - verilog/ysyx_23060208_regfile.sv
      - verilog/ysyx_23060208_alu.sv
      - verilog/ysyx_23060208_exu.sv
      - verilog/ysyx_23060208_core_top.sv
  - target: test
    include_dirs:
      - verilog
      - tb
    files:
      - tb/tb_core_top.sv

// ==== flist.f ====
+incdir+verilog
+incdir+tb
verilog/ysyx_23060208_pkg.sv
verilog/ysyx_23060208_idu.sv
verilog/ysyx_23060208_regfile.sv
verilog/ysyx_23060208_alu.sv
verilog/ysyx_23060208_exu.sv
verilog/ysyx_23060208_core_top.sv
tb/tb_core_top.sv

// ==== tb/tb_core_tasks.svh ====
//************************************************
// tb_core_tasks
// encoders, reference model, typed checks and
// the directed tests of the execute subsystem
//************************************************
`ifndef TB_CORE_TASKS_SVH
`define TB_CORE_TASKS_SVH

function automatic logic [31:0] enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3,
                                      input reg_idx_t rd);
  return {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                      input logic [2:0] f3, input reg_idx_t rd);
  return {imm, rs1, f3, rd, `OPC_OPIMM};
endfunction

function automatic logic [31:0] enc_u(input logic [6:0] opc, input logic [19:0] imm,
                                      input reg_idx_t rd);
  return {imm, rd, opc};
endfunction

// off is the 13-bit byte offset whose bit 0 is dropped
function automatic logic [31:0] enc_b(input logic [12:0] off, input reg_idx_t rs2,
                                      input reg_idx_t rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
endfunction

// RV32I arithmetic by funct3 where alt picks sub or sra
function automatic word_t ref_alu(input logic [2:0] f3, input logic alt,
                                  input word_t a, input word_t b);
  word_t r;
  case (f3)
    3'd0: r = alt ? a - b : a + b;
    3'd1: r = a << b[4:0];
    3'd2: r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'd3: r = (a < b) ? 32'd1 : 32'd0;
    3'd4: r = a ^ b;
    3'd5: begin
      if (alt) r = $signed(a) >>> b[4:0];
      else r = a >> b[4:0];
    end
    3'd6: r = a | b;
    default: r = a & b;
  endcase
  return r;
endfunction

// steps the model by one word and returns the expected retire
task automatic model_exec(input logic [31:0] w, output retire_t exp);
  reg_idx_t rd;
  logic [2:0] f3;
  word_t a;
  word_t b;
  word_t res;
  logic tk;
  rd  = w[11:7];
  f3  = w[14:12];
  a   = m_regs[w[19:15]];
  b   = m_regs[w[24:20]];
  res = '0;
  tk  = 1'b0;
  exp = '0;
  exp.pc = m_pc;
  exp.rd = rd;
  case (w[6:0])
    `OPC_OP: begin
      exp.wen = 1'b1;
      res = ref_alu(f3, w[30], a, b);
    end
    `OPC_OPIMM: begin
      // only srai reads bit 30
      exp.wen = 1'b1;
      res = ref_alu(f3, (f3 == 3'd5) & w[30], a, {{20{w[31]}}, w[31:20]});
    end
    `OPC_LUI: begin
      exp.wen = 1'b1;
      res = {w[31:12], 12'b0};
    end
    `OPC_AUIPC: begin
      exp.wen = 1'b1;
      res = m_pc + {w[31:12], 12'b0};
    end
    `OPC_BRANCH: begin
      case (f3)
        3'd0: tk = (a == b);
        3'd1: tk = (a != b);
        3'd4: tk = ($signed(a) < $signed(b));
        3'd5: tk = ($signed(a) >= $signed(b));
        3'd6: tk = (a < b);
        default: tk = (a >= b);
      endcase
      // decision bit comes back as the result
      res = {31'b0, tk};
    end
    default: exp.illegal = 1'b1;
  endcase
  exp.wdata = res;
  exp.taken = tk;
  if (exp.wen && rd != '0) m_regs[rd] = res;
  if (tk) m_pc = m_pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  else m_pc = m_pc + 32'd4;
endtask

task automatic check_retire(input string name, input retire_t exp, input retire_t act);
  if (act !== exp) begin
    $display("** Error [%s] retire expected %h actual %h", name, exp, act);
    errors++;
    abort_run();
  end
endtask

task automatic check_pc(input string name, input word_t exp, input word_t act);
  if (act !== exp) begin
    $display("** Error [%s] pc expected %h actual %h", name, exp, act);
    errors++;
    abort_run();
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("** Error [%s] retire_valid expected %b actual %b", name, exp, act);
    errors++;
    abort_run();
  end
endtask

// one-cycle issue checked on the next falling edge
task automatic issue(input string name, input logic [31:0] w);
  retire_t exp;
  model_exec(w, exp);
  inst_valid = 1'b1;
  inst       = w;
  @(posedge clock);
  @(negedge clock);
  inst_valid = 1'b0;
  check_flag(name, 1'b1, retire_valid);
  check_retire(name, exp, retire);
  check_pc(name, m_pc, pc);
endtask

// nothing issued at this edge so pc holds and no retire follows
task automatic idle_cycle(input string name);
  @(posedge clock);
  @(negedge clock);
  check_flag(name, 1'b0, retire_valid);
  check_pc(name, m_pc, pc);
endtask

// lui then addi with the upper part rounded for the signed low half
task automatic load_reg(input reg_idx_t rd, input word_t value);
  word_t up;
  up = value + 32'h800;
  issue("load_lui", enc_u(`OPC_LUI, up[31:12], rd));
  issue("load_addi", enc_i(value[11:0], rd, 3'b000, rd));
endtask

task automatic test_reset();
  check_pc("reset", `RESET_PC, pc);
  check_flag("reset", 1'b0, retire_valid);
  @(negedge clock);
  check_pc("idle", `RESET_PC, pc);
  check_flag("idle", 1'b0, retire_valid);
endtask

task automatic test_reg_reg();
  reg_idx_t   rs1_l [4] = '{5'd1, 5'd3, 5'd4, 5'd1};
  reg_idx_t   rs2_l [4] = '{5'd2, 5'd4, 5'd3, 5'd5};
  // add sub slt sltu and or xor sll srl sra
  logic [2:0] f3_l [10] = '{3'd0, 3'd0, 3'd2, 3'd3, 3'd7, 3'd6, 3'd4, 3'd1, 3'd5, 3'd5};
  logic [6:0] f7_l [10] = '{7'h00, 7'h20, 7'h00, 7'h00, 7'h00, 7'h00, 7'h00,
                            7'h00, 7'h00, 7'h20};
  load_reg(5'd1, $random(seed));
  load_reg(5'd2, $random(seed));
  load_reg(5'd3, 32'h8000_0000);
  load_reg(5'd4, 32'd1);
  // shift amount 5 with upper bits to be ignored
  load_reg(5'd5, 32'hffff_ffe5);
  for (int p = 0; p < 4; p++) begin
    for (int k = 0; k < 10; k++) begin
      issue("reg_reg", enc_r(f7_l[k], rs2_l[p], rs1_l[p], f3_l[k], 5'(10 + k)));
    end
  end
endtask

task automatic test_imm();
  // addi slti sltiu xori ori andi
  logic [2:0]  f3_l [6]  = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7};
  logic [11:0] imm_l [2] = '{12'hffb, 12'h800};
  logic [4:0]  sh_l [3]  = '{5'd1, 5'd31, 5'd12};
  reg_idx_t    src;
  load_reg(5'd6, $random(seed));
  load_reg(5'd7, 32'h8000_0010);
  for (int s = 0; s < 2; s++) begin
    src = 5'(6 + s);
    for (int k = 0; k < 12; k++) begin
      issue("imm", enc_i(imm_l[k % 2], src, f3_l[k / 2], 5'(23 + k % 6)));
    end
    for (int k = 0; k < 3; k++) begin
      issue("slli", enc_i({7'h00, sh_l[k]}, src, 3'd1, 5'd23));
      issue("srli", enc_i({7'h00, sh_l[k]}, src, 3'd5, 5'd24));
      issue("srai", enc_i({7'h20, sh_l[k]}, src, 3'd5, 5'd25));
    end
  end
  // dependent chain with each one issued the cycle after the last
  issue("chain", enc_i(12'hffd, 5'd7, 3'd0, 5'd21));
  issue("chain", enc_i(12'hffd, 5'd21, 3'd0, 5'd21));
  issue("chain", enc_i(12'hffd, 5'd21, 3'd0, 5'd21));
  issue("chain", enc_r(7'h00, 5'd21, 5'd21, 3'd0, 5'd22));
endtask

task automatic test_upper();
  word_t r;
  r = $random(seed);
  issue("lui", enc_u(`OPC_LUI, r[19:0], 5'd13));
  issue("auipc", enc_u(`OPC_AUIPC, 20'hfffff, 5'd14));
  issue("auipc", enc_u(`OPC_AUIPC, 20'h12345, 5'd15));
endtask

task automatic test_branches();
  // beq bne blt bge bltu bgeu
  logic [2:0]  f3_l [6]  = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  reg_idx_t    rs1_l [3] = '{5'd16, 5'd17, 5'd17};
  reg_idx_t    rs2_l [3] = '{5'd17, 5'd16, 5'd18};
  logic [12:0] off_l [3] = '{13'd16, 13'h1ff4, 13'd256};
  load_reg(5'd16, 32'hffff_fffe);
  load_reg(5'd17, 32'd3);
  load_reg(5'd18, 32'd3);
  for (int k = 0; k < 6; k++) begin
    for (int p = 0; p < 3; p++) begin
      issue("branch", enc_b(off_l[(k + p) % 3], rs2_l[p], rs1_l[p], f3_l[k]));
    end
  end
endtask

task automatic test_x0_illegal();
  issue("x0_addi", enc_i(12'd5, 5'd6, 3'd0, 5'd0));
  issue("x0_lui", enc_u(`OPC_LUI, 20'habcde, 5'd0));
  issue("x0_read", enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd19));
  // opcode 7'h7f is undefined and its rd field points at x6
  issue("illegal", 32'h1234_537f);
  issue("after_illegal", enc_i(12'd0, 5'd6, 3'd0, 5'd20));
  // retire_valid must drop once the issue stops
  idle_cycle("idle_after_retire");
endtask

`endif

// ==== tb/tb_core_top.sv ====
//************************************************
// tb_core_top
// directed testbench for the execute subsystem,
// reference register and pc model, watchdog
//************************************************
`include "ysyx_23060208_defines.svh"

module tb_core_top
  import ysyx_23060208_pkg::*;
();

  localparam int CLK_PERIOD = 8;
  // instructions or idle cycles issued by each test
  localparam int N_IDLE  = 1;
  localparam int N_RR    = 50;
  localparam int N_IMM   = 50;
  localparam int N_UPPER = 3;
  localparam int N_BR    = 24;
  localparam int N_X0    = 6;
  localparam int N_ISSUE = N_IDLE + N_RR + N_IMM + N_UPPER + N_BR + N_X0;
  // 50 spare cycles cover reset and the final edges
  localparam int TIMEOUT = (N_ISSUE + 50) * CLK_PERIOD;

  logic    clock;
  logic    arst_n;
  logic    inst_valid;
  inst_t   inst;
  word_t   pc;
  logic    retire_valid;
  retire_t retire;

  // architectural state as RV32I defines it
  word_t  m_regs [0:`NREGS-1];
  word_t  m_pc;
  integer seed;
  int     errors;

  ysyx_23060208_core_top u_dut (
    .clock        (clock),
    .arst_n       (arst_n),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  `include "tb_core_tasks.svh"

  initial begin
    clock      = 1'b0;
    arst_n     = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    seed       = 32'ha38b;
    errors     = 0;
    m_pc       = `RESET_PC;
    for (int i = 0; i < `NREGS; i++) begin
      m_regs[i] = '0;
    end
    fork
      begin
        #(TIMEOUT);
        $display("watchdog: tests did not finish within %0d time units", TIMEOUT);
        abort_run();
      end
    join_none
    // hold reset for 5 cycles and release it between edges
    repeat (5) @(posedge clock);
    @(negedge clock);
    arst_n = 1'b1;
    test_reset();
    test_reg_reg();
    test_imm();
    test_upper();
    test_branches();
    test_x0_illegal();
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog/ysyx_23060208_alu.sv ====
//************************************************
// ysyx_23060208 alu
// one-hot op alu, shared adder for add, sub,
// compares and branches, and-or result select
//************************************************
`include "ysyx_23060208_defines.svh"

module ysyx_23060208_alu
  import ysyx_23060208_pkg::*;
(
  input  alu_op_t alu_op,
  input  word_t   alu_src1,
  input  word_t   alu_src2,
  output word_t   alu_result
);

  logic          sub_op;
  word_t         adder_b;
  logic          adder_cin;
  logic [`XLEN:0] adder_sum;
  word_t         adder_result;
  logic          adder_cout;
  logic          signed_overflow;
  logic          less_signed;
  logic          less_unsigned;
  logic          equal;
  logic          cmp_bit;
  word_t         and_result;
  word_t         or_result;
  word_t         xor_result;
  word_t         sll_result;
  logic [2*`XLEN-1:0] sr_wide;
  word_t         sr_result;

  // every compare and branch subtracts
  assign sub_op = alu_op.op_sub | alu_op.op_slt | alu_op.op_sltu
                | alu_op.op_beq | alu_op.op_bne
                | alu_op.op_blt | alu_op.op_bltu
                | alu_op.op_bge | alu_op.op_bgeu;

  // a - b as a + ~b + 1
  assign adder_b   = sub_op ? ~alu_src2 : alu_src2;
  assign adder_cin = sub_op;
  assign adder_sum = {1'b0, alu_src1} + {1'b0, adder_b}
                   + {{`XLEN{1'b0}}, adder_cin};
  assign adder_result = adder_sum[`XLEN-1:0];
  assign adder_cout   = adder_sum[`XLEN];

  // operands of equal sign giving a result of the other sign
  assign signed_overflow = (alu_src1[`XLEN-1] == adder_b[`XLEN-1])
                        && (adder_result[`XLEN-1] != alu_src1[`XLEN-1]);

  assign less_signed   = adder_result[`XLEN-1] ^ signed_overflow;
  // no carry out of a - b means a borrow
  assign less_unsigned = ~adder_cout;
  assign equal         = ~(|adder_result);

  // compare decision, lands in bit 0
  assign cmp_bit = ((alu_op.op_slt  | alu_op.op_blt ) & less_signed)
                 | ((alu_op.op_sltu | alu_op.op_bltu) & less_unsigned)
                 | (alu_op.op_bge  & ~less_signed)
                 | (alu_op.op_bgeu & ~less_unsigned)
                 | (alu_op.op_beq  & equal)
                 | (alu_op.op_bne  & ~equal);

  assign and_result = alu_src1 & alu_src2;
  assign or_result  = alu_src1 | alu_src2;
  assign xor_result = alu_src1 ^ alu_src2;

  // shift amount is src2[4:0]
  assign sll_result = alu_src1 << alu_src2[4:0];
  // upper half filled with the sign for sra, zero for srl
  assign sr_wide    = {{`XLEN{alu_op.op_sra & alu_src1[`XLEN-1]}}, alu_src1}
                    >> alu_src2[4:0];
  assign sr_result  = sr_wide[`XLEN-1:0];

  assign alu_result = ({`XLEN{alu_op.op_add | alu_op.op_sub}} & adder_result)
                    | ({`XLEN{alu_op.op_and}} & and_result)
                    | ({`XLEN{alu_op.op_or }} & or_result)
                    | ({`XLEN{alu_op.op_xor}} & xor_result)
                    | ({`XLEN{alu_op.op_sll}} & sll_result)
                    | ({`XLEN{alu_op.op_srl | alu_op.op_sra}} & sr_result)
                    | ({`XLEN{alu_op.op_lui}} & alu_src2)
                    | {{(`XLEN-1){1'b0}}, cmp_bit};

endmodule

// ==== verilog/ysyx_23060208_core_top.sv ====
//************************************************
// ysyx_23060208 core top
// integer execute subsystem, decoder, regfile, exu
//************************************************
module ysyx_23060208_core_top
  import ysyx_23060208_pkg::*;
(
  input  logic    clock,
  input  logic    arst_n,
  input  logic    inst_valid,
  input  inst_t   inst,
  output word_t   pc,
  output logic    retire_valid,
  output retire_t retire
);

  dec_t     dec;
  word_t    rdata1;
  word_t    rdata2;
  logic     we;
  reg_idx_t waddr;
  word_t    wdata;

  // combinational decode of the issued word
  ysyx_23060208_idu u_idu (
    .inst (inst),
    .dec  (dec)
  );

  ysyx_23060208_regfile u_regfile (
    .clock  (clock),
    .arst_n (arst_n),
    .rs1    (dec.rs1),
    .rs2    (dec.rs2),
    .rdata1 (rdata1),
    .rdata2 (rdata2),
    .we     (we),
    .waddr  (waddr),
    .wdata  (wdata)
  );

  // write back, pc and retire all at the issue edge
  ysyx_23060208_exu u_exu (
    .clock        (clock),
    .arst_n       (arst_n),
    .inst_valid   (inst_valid),
    .dec          (dec),
    .rdata1       (rdata1),
    .rdata2       (rdata2),
    .we           (we),
    .waddr        (waddr),
    .wdata        (wdata),
    .pc           (pc),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

// ==== verilog/ysyx_23060208_defines.svh ====
//************************************************
// ysyx_23060208 defines
// widths, register count, reset pc and the RV32I
// major opcodes of the execute subsystem
//************************************************
`ifndef YSYX_23060208_DEFINES_SVH
`define YSYX_23060208_DEFINES_SVH

// data and pc width
`define XLEN 32
// architectural registers, x0 included
`define NREGS 32
// first pc after reset
`define RESET_PC 32'h8000_0000

// major opcodes, inst[6:0]
`define OPC_OP     7'b0110011
`define OPC_OPIMM  7'b0010011
`define OPC_LUI    7'b0110111
`define OPC_AUIPC  7'b0010111
`define OPC_BRANCH 7'b1100011

`endif

// ==== verilog/ysyx_23060208_exu.sv ====
//************************************************
// ysyx_23060208 exu
// operand select, alu, branch resolve, pc and retire
//************************************************
`include "ysyx_23060208_defines.svh"

module ysyx_23060208_exu
  import ysyx_23060208_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  input  logic     inst_valid,
  input  dec_t     dec,
  input  word_t    rdata1,
  input  word_t    rdata2,
  output logic     we,
  output reg_idx_t waddr,
  output word_t    wdata,
  output word_t    pc,
  output logic     retire_valid,
  output retire_t  retire
);

  word_t alu_src1;
  word_t alu_src2;
  word_t alu_result;
  logic  taken;
  word_t next_pc;

  always_comb begin
    case (dec.src1_sel)
      src1_pc:   alu_src1 = pc;
      src1_zero: alu_src1 = '0;
      default:   alu_src1 = rdata1;
    endcase
  end

  // branches compare two registers, imm is only the offset
  assign alu_src2 = (dec.src2_is_imm && !dec.is_branch) ? dec.imm : rdata2;

  ysyx_23060208_alu u_alu (
    .alu_op     (dec.alu_op),
    .alu_src1   (alu_src1),
    .alu_src2   (alu_src2),
    .alu_result (alu_result)
  );

  // write port, regfile drops x0
  assign we    = inst_valid & dec.wen & ~dec.illegal;
  assign waddr = dec.rd;
  assign wdata = alu_result;

  assign taken   = dec.is_branch & ~dec.illegal & alu_result[0];
  assign next_pc = taken ? (pc + dec.imm) : (pc + `XLEN'd4);

  // pc holds when no instruction is issued
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      pc <= `RESET_PC;
    end else if (inst_valid) begin
      pc <= next_pc;
    end
  end

  // retire pulse, one cycle after issue
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      retire_valid <= 1'b0;
      retire       <= '0;
    end else begin
      retire_valid <= inst_valid;
      if (inst_valid) begin
        retire.pc      <= pc;
        retire.rd      <= dec.rd;
        retire.wdata   <= alu_result;
        retire.wen     <= dec.wen & ~dec.illegal;
        retire.taken   <= taken;
        retire.illegal <= dec.illegal;
      end
    end
  end

endmodule

// ==== verilog/ysyx_23060208_idu.sv ====
//************************************************
// ysyx_23060208 idu
// RV32I decoder, instruction word to one-hot alu op,
// operand selects and sign-extended immediate
//************************************************
`include "ysyx_23060208_defines.svh"

module ysyx_23060208_idu
  import ysyx_23060208_pkg::*;
(
  input  inst_t inst,
  output dec_t  dec
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_b;
  word_t      imm_u;

  // opcode, funct3 and funct7 sit at the same place in every format
  assign opcode = inst.r_fmt.opcode;
  assign funct3 = inst.r_fmt.funct3;
  assign funct7 = inst.r_fmt.funct7;

  assign imm_i = {{(`XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
  // bit 0 of a branch offset is always zero
  assign imm_b = {{(`XLEN-12){inst.b_fmt.imm12}}, inst.b_fmt.imm11,
                  inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
  assign imm_u = {inst.u_fmt.imm31_12, 12'b0};

  always_comb begin
    logic bad;
    bad = 1'b0;
    dec = '0;
    dec.src1_sel = src1_reg;
    dec.rs1 = inst.r_fmt.rs1;
    dec.rs2 = inst.r_fmt.rs2;
    dec.rd  = inst.r_fmt.rd;
    case (opcode)
      `OPC_OP: begin
        dec.wen = 1'b1;
        case (funct3)
          3'b000: begin
            if (funct7 == 7'b0000000) dec.alu_op.op_add = 1'b1;
            else if (funct7 == 7'b0100000) dec.alu_op.op_sub = 1'b1;
            else bad = 1'b1;
          end
          3'b001: dec.alu_op.op_sll  = 1'b1;
          3'b010: dec.alu_op.op_slt  = 1'b1;
          3'b011: dec.alu_op.op_sltu = 1'b1;
          3'b100: dec.alu_op.op_xor  = 1'b1;
          3'b101: begin
            if (funct7 == 7'b0100000) dec.alu_op.op_sra = 1'b1;
            else dec.alu_op.op_srl = 1'b1;
          end
          3'b110: dec.alu_op.op_or   = 1'b1;
          default: dec.alu_op.op_and = 1'b1;
        endcase
        // only add/sub and srl/sra use funct7[5]
        if (funct7 != 7'b0000000 && !(funct7 == 7'b0100000 &&
            (funct3 == 3'b000 || funct3 == 3'b101)))
          bad = 1'b1;
      end
      `OPC_OPIMM: begin
        dec.wen = 1'b1;
        dec.src2_is_imm = 1'b1;
        dec.imm = imm_i;
        case (funct3)
          3'b000: dec.alu_op.op_add  = 1'b1;
          3'b010: dec.alu_op.op_slt  = 1'b1;
          3'b011: dec.alu_op.op_sltu = 1'b1;
          3'b100: dec.alu_op.op_xor  = 1'b1;
          3'b110: dec.alu_op.op_or   = 1'b1;
          3'b111: dec.alu_op.op_and  = 1'b1;
          3'b001: begin
            dec.alu_op.op_sll = 1'b1;
            bad = (funct7 != 7'b0000000);
          end
          default: begin
            // srli / srai, shamt in imm[4:0]
            if (funct7 == 7'b0100000) dec.alu_op.op_sra = 1'b1;
            else dec.alu_op.op_srl = 1'b1;
            bad = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
          end
        endcase
      end
      `OPC_LUI: begin
        // alu passes src2 straight through
        dec.wen = 1'b1;
        dec.alu_op.op_lui = 1'b1;
        dec.src1_sel = src1_zero;
        dec.src2_is_imm = 1'b1;
        dec.imm = imm_u;
      end
      `OPC_AUIPC: begin
        dec.wen = 1'b1;
        dec.alu_op.op_add = 1'b1;
        dec.src1_sel = src1_pc;
        dec.src2_is_imm = 1'b1;
        dec.imm = imm_u;
      end
      `OPC_BRANCH: begin
        // compares rs1 with rs2, imm is the target offset
        dec.is_branch = 1'b1;
        dec.imm = imm_b;
        case (funct3)
          3'b000: dec.alu_op.op_beq  = 1'b1;
          3'b001: dec.alu_op.op_bne  = 1'b1;
          3'b100: dec.alu_op.op_blt  = 1'b1;
          3'b101: dec.alu_op.op_bge  = 1'b1;
          3'b110: dec.alu_op.op_bltu = 1'b1;
          3'b111: dec.alu_op.op_bgeu = 1'b1;
          default: bad = 1'b1;
        endcase
      end
      default: bad = 1'b1;
    endcase
    // illegal word, no op and no write
    if (bad) begin
      dec.alu_op    = '0;
      dec.wen       = 1'b0;
      dec.is_branch = 1'b0;
      dec.illegal   = 1'b1;
    end
  end

endmodule

// ==== verilog/ysyx_23060208_pkg.sv ====
//************************************************
// ysyx_23060208 package
// shared types of decoder, alu and execute unit
//************************************************
`include "ysyx_23060208_defines.svh"

package ysyx_23060208_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0]       reg_idx_t;

  // one-hot alu control, op_add is bit 0
  typedef struct packed {
    logic op_bgeu;
    logic op_bge;
    logic op_bltu;
    logic op_blt;
    logic op_bne;
    logic op_beq;
    logic op_lui;
    logic op_sra;
    logic op_srl;
    logic op_sll;
    logic op_xor;
    logic op_or;
    logic op_and;
    logic op_sltu;
    logic op_slt;
    logic op_sub;
    logic op_add;
  } alu_op_t;

  // R-type, also gives rs1/rs2/rd/funct3 for the other formats
  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // branch offset scattered over the word
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  // one instruction word, four views
  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } inst_t;

  typedef enum logic [1:0] {
    src1_reg,
    src1_pc,
    src1_zero
  } src1_sel_t;

  // decoder to execute unit
  typedef struct packed {
    alu_op_t   alu_op;
    src1_sel_t src1_sel;
    logic      src2_is_imm;
    word_t     imm;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    logic      wen;
    logic      is_branch;
    logic      illegal;
  } dec_t;

  // retire report, one per issued instruction
  typedef struct packed {
    word_t    pc;
    reg_idx_t rd;
    word_t    wdata;
    logic     wen;
    logic     taken;
    logic     illegal;
  } retire_t;

endpackage

// ==== verilog/ysyx_23060208_regfile.sv ====
//************************************************
// ysyx_23060208 regfile
// 32x32 registers, two async reads, one write, x0 zero
//************************************************
`include "ysyx_23060208_defines.svh"

module ysyx_23060208_regfile
  import ysyx_23060208_pkg::*;
(
  input  logic     clock,
  input  logic     arst_n,
  input  reg_idx_t rs1,
  input  reg_idx_t rs2,
  output word_t    rdata1,
  output word_t    rdata2,
  input  logic     we,
  input  reg_idx_t waddr,
  input  word_t    wdata
);

  word_t regs [0:`NREGS-1];

  // x0 is never written
  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < `NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // reads see the value written at the previous edge
  assign rdata1 = (rs1 == '0) ? '0 : regs[rs1];
  assign rdata2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule
